// File: design/enc_pkg.sv
/* encoder trigger shared types */

package enc_pkg;

    // width of the register-style settings
    localparam int cfg_w = 32;

    // step decoding modes
    typedef enum logic [1:0] {
        cnt_single = 2'd0,  // A rising edges only
        cnt_x1     = 2'd1,  // A rising edges, direction from B
        cnt_x2     = 2'd2,  // both A edges
        cnt_x4     = 2'd3   // every edge of both channels
    } cnt_mode_e;

    // which motion may fire the trigger
    typedef enum logic {
        dir_forward = 1'b0,
        dir_both    = 1'b1
    } dir_mode_e;

    // static settings, held while en is high
    typedef struct packed {
        logic             en;
        logic [cfg_w-1:0] filt_time;    // stable time in clocks
        logic [cfg_w-1:0] skip_pulses;  // startup pulses to ignore
        cnt_mode_e        cnt_mode;
        dir_mode_e        dir_mode;
        logic [cfg_w-1:0] div;          // trigger distance in steps
    } enc_cfg_t;

    // one level per encoder channel
    typedef struct packed {
        logic a;
        logic b;
    } chan_t;

    // single-cycle edge flags of the clean channels
    typedef struct packed {
        logic a_rise;
        logic a_fall;
        logic b_rise;
        logic b_fall;
    } edges_t;

    // decoded motion, never both set in one cycle
    typedef struct packed {
        logic up;
        logic down;
    } step_t;

endpackage

// File: design/glitch_filter.sv
/* encoder channel glitch filter */

`timescale 1ns/1ps

module glitch_filter #(
    parameter int TIME_W = enc_pkg::cfg_w
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic [TIME_W-1:0] filt_time,
    input  logic              raw,
    output logic              level
);

    // two-flop synchronizer, sync_q[1] is the usable copy
    logic [1:0]        sync_q;
    logic [TIME_W-1:0] stable_cnt;
    logic              about_to_change;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[0], raw};
        end
    end

    // second stage takes a new value on the next edge
    assign about_to_change = sync_q[0] ^ sync_q[1];

    // clocks the synchronized value has held, stops at filt_time
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stable_cnt <= '0;
        end else if (!en || about_to_change) begin
            stable_cnt <= '0;
        end else if (stable_cnt != filt_time) begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // new level is accepted once it has held filt_time+1 clocks
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level <= 1'b0;
        end else if (!en) begin
            // follow the pin so enabling does not create a false edge
            level <= sync_q[1];
        end else if (stable_cnt == filt_time) begin
            level <= sync_q[1];
        end
    end

endmodule

// File: design/startup_gate.sv
/* startup pulse skip gate */

`timescale 1ns/1ps

module startup_gate (
    input  logic              clk,
    input  logic              rst,
    input  enc_pkg::enc_cfg_t cfg,
    input  enc_pkg::edges_t   edges,
    output logic              tracking
);

    import enc_pkg::*;

    typedef enum logic [1:0] {
        gate_off   = 2'd0,
        gate_skip  = 2'd1,
        gate_track = 2'd2
    } gate_state_e;

    gate_state_e      state;
    gate_state_e      state_next;
    logic [cfg_w-1:0] skip_a_cnt;
    logic [cfg_w-1:0] skip_b_cnt;
    logic             skip_a_done;
    logic             skip_b_full;
    logic             skip_b_done;

    assign skip_a_done = (skip_a_cnt == cfg.skip_pulses);
    assign skip_b_full = (skip_b_cnt == cfg.skip_pulses);

    // B is not wired up in single channel mode
    assign skip_b_done = skip_b_full || (cfg.cnt_mode == cnt_single);

    // rising edges seen per channel while skipping
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            skip_a_cnt <= '0;
            skip_b_cnt <= '0;
        end else if (!cfg.en) begin
            skip_a_cnt <= '0;
            skip_b_cnt <= '0;
        end else if (state == gate_skip) begin
            if (edges.a_rise && !skip_a_done) begin
                skip_a_cnt <= skip_a_cnt + 1'b1;
            end
            if (edges.b_rise && !skip_b_full) begin
                skip_b_cnt <= skip_b_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            gate_off: begin
                // counters are zero here, so done means nothing to skip
                if (cfg.en) begin
                    state_next = (skip_a_done && skip_b_done) ? gate_track : gate_skip;
                end
            end
            gate_skip: begin
                if (!cfg.en) begin
                    state_next = gate_off;
                end else if (skip_a_done && skip_b_done) begin
                    state_next = gate_track;
                end
            end
            gate_track: begin
                if (!cfg.en) begin
                    state_next = gate_off;
                end
            end
            default: state_next = gate_off;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= gate_off;
        end else begin
            state <= state_next;
        end
    end

    assign tracking = (state == gate_track);

endmodule

// File: design/quad_decoder.sv
/* quadrature edge and step decoder */

`timescale 1ns/1ps

module quad_decoder (
    input  logic              clk,
    input  logic              rst,
    input  enc_pkg::enc_cfg_t cfg,
    input  enc_pkg::chan_t    clean,
    input  logic              tracking,
    output enc_pkg::edges_t   edges,
    output enc_pkg::step_t    step
);

    import enc_pkg::*;

    chan_t clean_q;
    logic  step_up;
    logic  step_down;

    // previous clean levels for edge detection
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clean_q <= '0;
        end else begin
            clean_q <= clean;
        end
    end

    assign edges = '{
        a_rise: clean.a & ~clean_q.a,
        a_fall: ~clean.a & clean_q.a,
        b_rise: clean.b & ~clean_q.b,
        b_fall: ~clean.b & clean_q.b
    };

    // forward order is 00 -> 10 -> 11 -> 01 -> 00 with A leading
    always_comb begin
        step_up   = 1'b0;
        step_down = 1'b0;
        case (cfg.cnt_mode)
            cnt_single: begin
                step_up = edges.a_rise;
            end
            cnt_x1: begin
                step_up   = edges.a_rise & ~clean.b;
                step_down = edges.a_rise & clean.b;
            end
            cnt_x2: begin
                step_up   = (edges.a_rise & ~clean.b) | (edges.a_fall & clean.b);
                step_down = (edges.a_rise & clean.b) | (edges.a_fall & ~clean.b);
            end
            cnt_x4: begin
                step_up   = (edges.a_rise & ~clean.b) | (edges.a_fall & clean.b)
                          | (edges.b_rise & clean.a) | (edges.b_fall & ~clean.a);
                step_down = (edges.a_rise & clean.b) | (edges.a_fall & ~clean.b)
                          | (edges.b_rise & ~clean.a) | (edges.b_fall & clean.a);
            end
            default: begin
                step_up   = 1'b0;
                step_down = 1'b0;
            end
        endcase
    end

    // both channels moving in one cycle is not a legal step, drop it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step <= '0;
        end else if (!tracking) begin
            step <= '0;
        end else begin
            step <= '{up: step_up & ~step_down, down: step_down & ~step_up};
        end
    end

endmodule

// File: design/position_divider.sv
/* position counter and trigger divider */

`timescale 1ns/1ps

module position_divider #(
    // must stay wider than the div setting
    parameter int POS_W = 40
) (
    input  logic              clk,
    input  logic              rst,
    input  enc_pkg::enc_cfg_t cfg,
    input  enc_pkg::step_t    step,
    output logic              trigger
);

    import enc_pkg::*;

    logic signed [POS_W-1:0] position;
    logic signed [POS_W-1:0] mark;
    logic signed [POS_W-1:0] position_next;
    logic        [POS_W-1:0] dist_fwd;
    logic        [POS_W-1:0] dist_back;
    logic        [POS_W-1:0] div_ext;
    logic                    fire_fwd;
    logic                    fire_back;

    always_comb begin
        position_next = position;
        if (step.up) begin
            position_next = position + POS_W'(1);
        end else if (step.down) begin
            position_next = position - POS_W'(1);
        end
    end

    // distance from the last mark, a negative result never matches div
    assign dist_fwd  = position_next - mark;
    assign dist_back = mark - position_next;
    assign div_ext   = POS_W'(cfg.div);

    assign fire_fwd  = step.up && (dist_fwd == div_ext);
    assign fire_back = step.down && (cfg.dir_mode == dir_both) && (dist_back == div_ext);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            position <= '0;
            mark     <= '0;
            trigger  <= 1'b0;
        end else if (!cfg.en) begin
            position <= '0;
            mark     <= '0;
            trigger  <= 1'b0;
        end else begin
            position <= position_next;
            trigger  <= fire_fwd | fire_back;
            // in forward mode the mark stays put while running backward
            if (fire_fwd || fire_back) begin
                mark <= position_next;
            end
        end
    end

endmodule

// File: design/encoder_trigger.sv
/* rotary encoder trigger generator */

`timescale 1ns/1ps

module encoder_trigger #(
    parameter int POS_W  = 40,
    parameter int TIME_W = enc_pkg::cfg_w
) (
    input  logic              clk,
    input  logic              rst,
    input  enc_pkg::enc_cfg_t cfg,
    input  enc_pkg::chan_t    enc_in,
    output logic              trigger
);

    import enc_pkg::*;

    logic   clean_a;
    logic   clean_b;
    chan_t  clean;
    edges_t edges;
    step_t  step;
    logic   tracking;

    glitch_filter #(
        .TIME_W    (TIME_W)
    ) chan_a_filter (
        .clk       (clk),
        .rst       (rst),
        .en        (cfg.en),
        .filt_time (TIME_W'(cfg.filt_time)),
        .raw       (enc_in.a),
        .level     (clean_a)
    );

    glitch_filter #(
        .TIME_W    (TIME_W)
    ) chan_b_filter (
        .clk       (clk),
        .rst       (rst),
        .en        (cfg.en),
        .filt_time (TIME_W'(cfg.filt_time)),
        .raw       (enc_in.b),
        .level     (clean_b)
    );

    assign clean = '{a: clean_a, b: clean_b};

    startup_gate startup_gate_inst (
        .clk      (clk),
        .rst      (rst),
        .cfg      (cfg),
        .edges    (edges),
        .tracking (tracking)
    );

    quad_decoder quad_decoder_inst (
        .clk      (clk),
        .rst      (rst),
        .cfg      (cfg),
        .clean    (clean),
        .tracking (tracking),
        .edges    (edges),
        .step     (step)
    );

    position_divider #(
        .POS_W   (POS_W)
    ) position_divider_inst (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg),
        .step    (step),
        .trigger (trigger)
    );

endmodule

// File: tb/encoder_tests.svh
/* encoder directed tests */

`ifndef encoder_tests_svh
`define encoder_tests_svh

    // each pin level outlasts the filter and synchronizer
    function automatic int hold_cycles();
        return int'(cfg.filt_time) + 4;
    endfunction

    // drop en, load new settings while disabled, then enable again
    task automatic restart(input int filt, input int skip, input cnt_mode_e mode,
                           input dir_mode_e dir, input int div);
        cfg.en = 1'b0;
        wait_cycles(3);
        cfg.filt_time   = filt;
        cfg.skip_pulses = skip;
        cfg.cnt_mode    = mode;
        cfg.dir_mode    = dir;
        cfg.div         = div;
        cfg.en          = 1'b1;
        wait_cycles(3);
    endtask

    task automatic set_pins(input logic a, input logic b);
        enc_in.a = a;
        enc_in.b = b;
        wait_cycles(hold_cycles());
    endtask

    // A leads B going forward
    task automatic forward_cycle();
        set_pins(1'b1, 1'b0);
        set_pins(1'b1, 1'b1);
        set_pins(1'b0, 1'b1);
        set_pins(1'b0, 1'b0);
    endtask

    task automatic backward_cycle();
        set_pins(1'b0, 1'b1);
        set_pins(1'b1, 1'b1);
        set_pins(1'b1, 1'b0);
        set_pins(1'b0, 1'b0);
    endtask

    task automatic a_pulse();
        set_pins(1'b1, 1'b0);
        set_pins(1'b0, 1'b0);
    endtask

    // short high on A, at most filt_time-2 clocks
    task automatic a_glitch();
        int len;
        draw_bits(8, len);
        len = 1 + len % (int'(cfg.filt_time) - 2);
        enc_in.a = 1'b1;
        wait_cycles(len);
        enc_in.a = 1'b0;
        wait_cycles(hold_cycles());
    endtask

    // let the pipeline drain, then count triggers since start
    task automatic settle_and_count(inout int start, output int got);
        wait_cycles(idle_cycles);
        got   = trig_count - start;
        start = trig_count;
    endtask

    task automatic test_single_channel();
        int errs;
        int start;
        int got;
        errs  = error_count;
        restart(2, 0, cnt_single, dir_forward, 3);
        start = trig_count;
        repeat (7) a_pulse();
        settle_and_count(start, got);
        if (got != 7 / 3) report_mismatch("single channel", got, 7 / 3);
        finish_test("single_channel", errs);
    endtask

    task automatic test_glitch_reject();
        int errs;
        int start;
        int got;
        errs  = error_count;
        restart(6, 0, cnt_single, dir_forward, 2);
        start = trig_count;
        repeat (6) begin
            a_pulse();
            a_glitch();
        end
        settle_and_count(start, got);
        if (got != 6 / 2) report_mismatch("glitch reject", got, 6 / 2);
        finish_test("glitch_reject", errs);
    endtask

    // first 3 cycles are skipped, 7 steps remain
    task automatic test_startup_skip();
        int errs;
        int start;
        int got;
        errs  = error_count;
        restart(2, 3, cnt_x1, dir_forward, 2);
        start = trig_count;
        repeat (10) forward_cycle();
        settle_and_count(start, got);
        if (got != (10 - 3) / 2) report_mismatch("startup skip", got, (10 - 3) / 2);
        finish_test("startup_skip", errs);
    endtask

    task automatic test_full_quadrature();
        int errs;
        int start;
        int got;
        errs  = error_count;
        restart(2, 0, cnt_x4, dir_forward, 6);
        start = trig_count;
        repeat (5) forward_cycle();
        settle_and_count(start, got);
        if (got != 4 * 5 / 6) report_mismatch("x4 forward", got, 4 * 5 / 6);
        repeat (2) backward_cycle();
        settle_and_count(start, got);
        if (got != 0) report_mismatch("x4 backward", got, 0);
        // climbing back to the old position fires nothing
        repeat (2) forward_cycle();
        settle_and_count(start, got);
        if (got != 0) report_mismatch("x4 recover", got, 0);
        repeat (4) forward_cycle();
        settle_and_count(start, got);
        if (got != ((4 * 5) % 6 + 4 * 4) / 6) begin
            report_mismatch("x4 resume", got, ((4 * 5) % 6 + 4 * 4) / 6);
        end
        finish_test("full_quadrature", errs);
    endtask

    task automatic test_bidirectional();
        int errs;
        int start;
        int got;
        errs  = error_count;
        restart(2, 0, cnt_x2, dir_both, 4);
        start = trig_count;
        repeat (6) forward_cycle();
        settle_and_count(start, got);
        if (got != 2 * 6 / 4) report_mismatch("x2 forward", got, 2 * 6 / 4);
        repeat (6) backward_cycle();
        settle_and_count(start, got);
        if (got != 2 * 6 / 4) report_mismatch("x2 backward", got, 2 * 6 / 4);
        finish_test("bidirectional", errs);
    endtask

    // two leftover steps would add a trigger if they survived the disable
    task automatic test_disable_clears();
        int errs;
        int start;
        int got;
        errs = error_count;
        restart(2, 0, cnt_single, dir_forward, 3);
        repeat (2) a_pulse();
        restart(2, 0, cnt_single, dir_forward, 3);
        start = trig_count;
        repeat (7) a_pulse();
        settle_and_count(start, got);
        if (got != 7 / 3) report_mismatch("after disable", got, 7 / 3);
        finish_test("disable_clears", errs);
    endtask

`endif

// File: tb/tb_encoder_trigger.sv
/* encoder trigger testbench */

`timescale 1ns/1ps

module tb_encoder_trigger;

    import enc_pkg::*;

    // six tests take roughly 1800 cycles, limit is about twice that
    localparam int cycle_limit = 4000;
    localparam int idle_cycles = 50;

    logic        clk;
    logic        rst;
    enc_cfg_t    cfg;
    chan_t       enc_in;
    logic        trigger;

    logic        trigger_q;
    int          trig_count;
    int          cycle_count;
    int          error_count;
    int          test_count;
    logic [15:0] lfsr_state;

    encoder_trigger #(
        .POS_W   (40),
        .TIME_W  (cfg_w)
    ) encoder_trigger_inst (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg),
        .enc_in  (enc_in),
        .trigger (trigger)
    );

    always #4 clk = ~clk;

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string what, input int got, input int expected);
        error_count = error_count + 1;
        $display("** Error trig_count (%s): got 0x%0h, expected 0x%0h", what, got, expected);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count = test_count + 1;
        if (error_count == errs_before) begin
            $display("test %-20s ok", name);
        end else begin
            $display("test %-20s FAILED", name);
        end
    endtask

    // trigger monitor, sampled away from the rising edge
    always @(negedge clk) begin
        if (trigger) begin
            trig_count = trig_count + 1;
            if (trigger_q) begin
                error_count = error_count + 1;
                $display("trigger stayed high for more than one cycle");
            end
        end
        trigger_q = trigger;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    `include "encoder_tests.svh"

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cfg         = '0;
        enc_in      = '0;
        trigger_q   = 1'b0;
        trig_count  = 0;
        cycle_count = 0;
        error_count = 0;
        test_count  = 0;
        lfsr_state  = 16'd33274;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_cycles(2);
        test_single_channel();
        test_glitch_reject();
        test_startup_skip();
        test_full_quadrature();
        test_bidirectional();
        test_disable_clears();
        $display("tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+tb
design/enc_pkg.sv
design/glitch_filter.sv
design/startup_gate.sv
design/quad_decoder.sv
design/position_divider.sv
design/encoder_trigger.sv
tb/tb_encoder_trigger.sv
